/* verilog/fp_pkg.sv */
/*
 * Shared definitions for the single-lane floating point unit
 * Format widths, opcodes, APB register map and controller states
 */
`default_nettype none

package fp_pkg;
	// IEEE-754 single precision word
	typedef logic [31:0] float_t;
	typedef logic [7:0] exponent_t;
	// Significand with the hidden bit in bit 23
	typedef logic [23:0] significand_t;
	typedef logic [47:0] product_t;
	typedef logic [5:0] norm_shift_t;

	// Opcode field of the control register
	typedef enum logic [2:0] {
		OP_FADD = 3'd0,
		OP_FSUB = 3'd1,
		OP_FMUL = 3'd2,
		OP_FGT = 3'd3,
		OP_FLT = 3'd4,
		OP_FEQ = 3'd5
	} fp_op_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_ALIGN,
		ST_MULTIPLY,
		ST_NORMALIZE,
		ST_DONE
	} ctrl_state_t;

	typedef logic [4:0] apb_addr_t;

	localparam apb_addr_t REG_OPERAND_A = 5'h00;
	localparam apb_addr_t REG_OPERAND_B = 5'h04;
	localparam apb_addr_t REG_CONTROL = 5'h08;
	localparam apb_addr_t REG_STATUS = 5'h0c;
	localparam apb_addr_t REG_RESULT = 5'h10;

	// Quiet NaN returned for every invalid operation
	localparam float_t FLOAT_QNAN = 32'h7fffffff;
endpackage

`default_nettype wire

/* verilog/fp_stage_if.sv */
/*
 * Stage link from the align and multiply blocks to normalize/round
 * Carries one operation in flight
 */
`timescale 1ns/100ps
`default_nettype none

interface fp_stage_if;
	import fp_pkg::*;

	fp_op_t op;
	logic is_inf;
	logic is_nan;
	// Sum path
	logic add_sign;
	logic logical_subtract;
	exponent_t add_exponent;
	// Carry in bit 31, significand in 30:7, alignment bits in 6:0
	logic [31:0] add_significand;
	norm_shift_t norm_shift;
	// Product path
	logic mul_sign;
	exponent_t mul_exponent;
	product_t product;

	modport front(output op, is_inf, is_nan, add_sign, logical_subtract, add_exponent,
		add_significand, norm_shift, mul_sign, mul_exponent, product);
	modport back(input op, is_inf, is_nan, add_sign, logical_subtract, add_exponent,
		add_significand, norm_shift, mul_sign, mul_exponent, product);
endinterface

`default_nettype wire

/* verilog/fp_apb_regs.sv */
/*
 * APB register block of the floating point unit
 * Holds operands and opcode, issues the start pulse, returns status and result
 */
`timescale 1ns/100ps
`default_nettype none

module fp_apb_regs(
	input wire clk,
	input wire reset,
	input wire fp_pkg::apb_addr_t paddr,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output fp_pkg::float_t operand_a,
	output fp_pkg::float_t operand_b,
	output fp_pkg::fp_op_t op,
	output logic start,
	input wire busy,
	input wire done,
	input wire fp_pkg::float_t result);

	import fp_pkg::*;

	logic access;
	logic mapped;
	logic bad_write;
	logic write_ok;

	// Transfers complete in the access phase, no wait states
	assign access = psel && penable;
	assign pready = 1'b1;
	assign mapped = paddr inside {REG_OPERAND_A, REG_OPERAND_B, REG_CONTROL, REG_STATUS,
		REG_RESULT};

	// Status and result are read only
	// A pending start pulse counts as busy
	assign bad_write = pwrite && (paddr == REG_STATUS || paddr == REG_RESULT
		|| (paddr == REG_CONTROL && (busy || start)));
	assign pslverr = access && (!mapped || bad_write);
	assign write_ok = access && pwrite && mapped && !bad_write;

	always_ff @(posedge clk)
	begin
		if (write_ok && paddr == REG_OPERAND_A)
			operand_a <= pwdata;

		if (write_ok && paddr == REG_OPERAND_B)
			operand_b <= pwdata;
	end

	// Control write latches the opcode and fires start one cycle later
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			op <= OP_FADD;
			start <= 1'b0;
		end
		else
		begin
			start <= write_ok && paddr == REG_CONTROL;
			if (write_ok && paddr == REG_CONTROL)
				op <= fp_op_t'(pwdata[2:0]);
		end
	end

	always_comb
	begin
		case (paddr)
			REG_OPERAND_A: prdata = operand_a;
			REG_OPERAND_B: prdata = operand_b;
			REG_CONTROL: prdata = {29'd0, op};
			REG_STATUS: prdata = {30'd0, done, busy};
			REG_RESULT: prdata = result;
			default: prdata = '0;
		endcase
	end

	// Controller never sees a new start during an operation
	assert property (@(posedge clk) disable iff (reset) start |-> !busy);
endmodule

`default_nettype wire

/* verilog/fp_op_ctrl.sv */
/*
 * Operation sequencer of the floating point unit
 * Steps through align, multiply iterations, normalize and done
 */
`timescale 1ns/100ps
`default_nettype none

module fp_op_ctrl #(
	parameter int MUL_RADIX_BITS = 2
)(
	input wire clk,
	input wire reset,
	input wire start,
	input wire fp_pkg::fp_op_t op,
	input wire last_step,
	output logic align_en,
	output logic mul_start,
	output logic mul_step,
	output logic norm_en,
	output logic busy,
	output logic done);

	import fp_pkg::*;

	localparam int MUL_STEPS = 24 / MUL_RADIX_BITS;

	ctrl_state_t state;
	ctrl_state_t next_state;

	always_comb
	begin
		next_state = state;
		case (state)
			ST_IDLE, ST_DONE:
				if (start)
					next_state = ST_ALIGN;

			// Only multiply goes through the iteration loop
			ST_ALIGN: next_state = op == OP_FMUL ? ST_MULTIPLY : ST_NORMALIZE;
			ST_MULTIPLY:
				if (last_step)
					next_state = ST_NORMALIZE;

			ST_NORMALIZE: next_state = ST_DONE;
			default: next_state = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			state <= ST_IDLE;
		else
			state <= next_state;
	end

	assign align_en = state == ST_ALIGN;
	// Multiplier loads together with the front stage
	assign mul_start = state == ST_ALIGN && op == OP_FMUL;
	assign mul_step = state == ST_MULTIPLY;
	assign norm_en = state == ST_NORMALIZE;
	assign busy = state inside {ST_ALIGN, ST_MULTIPLY, ST_NORMALIZE};
	// Held until the next operation leaves ST_DONE
	assign done = state == ST_DONE;

	// Load, then exactly one step per iteration, then normalize
	assert property (@(posedge clk) disable iff (reset)
		mul_start |=> mul_step [*MUL_STEPS] ##1 norm_en);
endmodule

`default_nettype wire

/* verilog/fp_step_counter.sv */
/*
 * Loadable down counter for the multiplier iterations
 * Flags the final step
 */
`timescale 1ns/100ps
`default_nettype none

module fp_step_counter #(
	parameter int WIDTH = 5
)(
	input wire clk,
	input wire reset,
	input wire load,
	input wire step,
	input wire [WIDTH-1:0] steps,
	output logic last_step);

	logic [WIDTH-1:0] count;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			count <= '0;
		else if (load)
			count <= steps;
		else if (step)
			count <= count - 1'b1;
	end

	// One step left
	assign last_step = count == WIDTH'(1);

	// Controller stops stepping once the count runs out
	assert property (@(posedge clk) disable iff (reset) step |-> count != '0);
endmodule

`default_nettype wire

/* verilog/fp_unpack_align.sv */
/*
 * Unpack and align stage
 * Classifies special operands, aligns and adds significands,
 * finds the normalization shift and the product exponent
 */
`timescale 1ns/100ps
`default_nettype none

module fp_unpack_align(
	input wire clk,
	input wire reset,
	input wire align_en,
	input wire fp_pkg::float_t operand_a,
	input wire fp_pkg::float_t operand_b,
	input wire fp_pkg::fp_op_t op,
	fp_stage_if.front stage);

	import fp_pkg::*;

	localparam exponent_t EXP_BIAS = 8'd127;

	exponent_t a_exp;
	exponent_t b_exp;
	significand_t a_sig;
	significand_t b_sig;
	logic a_sign;
	logic b_sign_eff;
	logic a_nan, b_nan, a_inf, b_inf, a_zero, b_zero;
	logic swap;
	exponent_t exp_diff;
	logic [31:0] big_sig;
	logic [31:0] small_sig;
	logic [31:0] sum;
	logic logical_sub;
	logic nan_result;
	norm_shift_t lead_zeros;

	assign a_sign = operand_a[31];
	assign a_exp = operand_a[30:23];
	assign b_exp = operand_b[30:23];
	// Hidden bit is clear for zero and subnormal inputs
	assign a_sig = {a_exp != '0, operand_a[22:0]};
	assign b_sig = {b_exp != '0, operand_b[22:0]};

	// Subtract and compares add the negated B
	// A compare then reads the sign and zero state of A minus B
	assign b_sign_eff = operand_b[31] ^ (op != OP_FADD);

	assign a_nan = a_exp == 8'hff && operand_a[22:0] != '0;
	assign b_nan = b_exp == 8'hff && operand_b[22:0] != '0;
	assign a_inf = a_exp == 8'hff && operand_a[22:0] == '0;
	assign b_inf = b_exp == 8'hff && operand_b[22:0] == '0;
	assign a_zero = operand_a[30:0] == '0;
	assign b_zero = operand_b[30:0] == '0;

	// Larger magnitude first so the sum stays non-negative
	assign swap = operand_b[30:0] > operand_a[30:0];
	assign exp_diff = swap ? b_exp - a_exp : a_exp - b_exp;
	assign big_sig = {1'b0, swap ? b_sig : a_sig, 7'd0};
	// Smaller operand loses bits off the bottom, none are kept as sticky
	assign small_sig = {1'b0, swap ? a_sig : b_sig, 7'd0} >> exp_diff;
	assign logical_sub = a_sign ^ b_sign_eff;
	assign sum = logical_sub ? big_sig - small_sig : big_sig + small_sig;

	// Leading zero count, 32 for an exact zero
	always_comb
	begin
		lead_zeros = 6'd32;
		for (int i = 0; i < 32; i++)
		begin
			if (sum[i])
				lead_zeros = norm_shift_t'(31 - i);
		end
	end

	// Invalid operations give NaN, compares only see NaN inputs
	always_comb
	begin
		nan_result = a_nan || b_nan;
		if (op == OP_FMUL)
			nan_result = nan_result || (a_inf && b_zero) || (b_inf && a_zero);
		else if (op == OP_FADD || op == OP_FSUB)
			nan_result = nan_result || (a_inf && b_inf && logical_sub);
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			stage.op <= OP_FADD;
			stage.is_nan <= 1'b0;
			stage.is_inf <= 1'b0;
		end
		else if (align_en)
		begin
			stage.op <= op;
			stage.is_nan <= nan_result;
			stage.is_inf <= (a_inf || b_inf) && !nan_result;
		end
	end

	always_ff @(posedge clk)
	begin
		if (align_en)
		begin
			stage.add_sign <= swap ? b_sign_eff : a_sign;
			stage.logical_subtract <= logical_sub;
			stage.add_exponent <= swap ? b_exp : a_exp;
			stage.add_significand <= sum;
			stage.norm_shift <= lead_zeros;
			stage.mul_sign <= a_sign ^ operand_b[31];
			// Wraps on underflow, no subnormal products
			stage.mul_exponent <= a_exp + b_exp - EXP_BIAS;
		end
	end
endmodule

`default_nettype wire

/* verilog/fp_seq_multiplier.sv */
/*
 * Sequential significand multiplier
 * Shift-and-add, retires MUL_RADIX_BITS bits of B per step
 */
`timescale 1ns/100ps
`default_nettype none

module fp_seq_multiplier #(
	parameter int MUL_RADIX_BITS = 2
)(
	input wire clk,
	input wire reset,
	input wire mul_start,
	input wire mul_step,
	input wire fp_pkg::significand_t mul_a,
	input wire fp_pkg::significand_t mul_b,
	fp_stage_if.front stage);

	import fp_pkg::*;

	significand_t multiplicand;
	// Upper half accumulates, lower half holds the B bits not yet retired
	product_t acc;
	logic [MUL_RADIX_BITS-1:0] digit;
	logic [23+MUL_RADIX_BITS:0] partial_sum;

	assign digit = acc[MUL_RADIX_BITS-1:0];
	// Never overflows 24 + MUL_RADIX_BITS bits
	assign partial_sum = {{MUL_RADIX_BITS{1'b0}}, acc[47:24]} + multiplicand * digit;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			multiplicand <= '0;
			acc <= '0;
		end
		else if (mul_start)
		begin
			multiplicand <= mul_a;
			acc <= {24'd0, mul_b};
		end
		else if (mul_step)
			acc <= product_t'({partial_sum, acc[23:0]} >> MUL_RADIX_BITS);
	end

	// Full product after the last step
	assign stage.product = acc;
endmodule

`default_nettype wire

/* verilog/fp_normalize_round.sv */
/*
 * Normalize and round stage
 * Normalizes and rounds sum and product, applies infinity and NaN,
 * evaluates compares and registers the selected result
 */
`timescale 1ns/100ps
`default_nettype none

module fp_normalize_round(
	input wire clk,
	input wire reset,
	input wire norm_en,
	fp_stage_if.back stage,
	output fp_pkg::float_t result);

	import fp_pkg::*;

	logic [31:0] shifted;
	exponent_t add_exp_adj;
	logic sum_is_zero;
	logic add_is_subnormal;
	logic add_round;
	logic [22:0] add_frac;
	exponent_t add_exp;
	float_t add_result;
	logic compare_result;
	logic mul_norm_shift;
	logic [22:0] mul_frac;
	logic mul_guard;
	logic mul_round;
	logic [21:0] mul_sticky_bits;
	logic mul_do_round;
	logic [22:0] mul_rounded;
	logic mul_hidden;
	logic mul_round_ovf;
	exponent_t mul_exp;
	float_t mul_result;

	// Leading one lands in bit 31, fraction in 30:8, guard in bit 7
	assign shifted = stage.add_significand << stage.norm_shift;
	// Unshifted sum has its hidden bit in bit 30
	assign add_exp_adj = stage.add_exponent + 8'd1 - {2'b00, stage.norm_shift};
	assign sum_is_zero = stage.add_significand == '0;
	assign add_is_subnormal = stage.add_exponent == '0 || sum_is_zero;

	// Only the guard bit is seen, round to even on guard and odd
	assign add_round = shifted[7] && shifted[8] && !stage.logical_subtract;
	assign add_frac = add_is_subnormal ? stage.add_significand[29:7]
		: shifted[30:8] + {22'd0, add_round};
	assign add_exp = add_is_subnormal ? '0 : add_exp_adj;

	always_comb
	begin
		if (stage.is_nan)
			add_result = FLOAT_QNAN;
		else if (stage.is_inf)
			add_result = {stage.add_sign, 8'hff, 23'd0};
		else if (sum_is_zero)
			add_result = '0;
		else
			add_result = {stage.add_sign, add_exp, add_frac};
	end

	// Unordered operands compare false
	always_comb
	begin
		case (stage.op)
			OP_FGT: compare_result = !stage.add_sign && !sum_is_zero && !stage.is_nan;
			OP_FLT: compare_result = stage.add_sign && !sum_is_zero && !stage.is_nan;
			OP_FEQ: compare_result = sum_is_zero && !stage.is_nan;
			default: compare_result = 1'b0;
		endcase
	end

	// Normal operands put the leading one in bit 47 or 46
	assign mul_norm_shift = !stage.product[47];
	assign {mul_frac, mul_guard, mul_round, mul_sticky_bits} = mul_norm_shift
		? {stage.product[45:0], 1'b0}
		: stage.product[46:0];
	// Nearest-even, ties go up only from an odd fraction
	assign mul_do_round = mul_guard && (mul_round || |mul_sticky_bits || mul_frac[0]);
	assign mul_rounded = mul_frac + {22'd0, mul_do_round};
	assign mul_hidden = stage.product[47] || stage.product[46];
	assign mul_round_ovf = mul_do_round && mul_rounded == '0;

	// Flushes to exponent 0 with no hidden bit
	assign mul_exp = mul_hidden
		? stage.mul_exponent + {7'd0, !mul_norm_shift} + {7'd0, mul_round_ovf}
		: '0;

	always_comb
	begin
		if (stage.is_nan)
			mul_result = FLOAT_QNAN;
		else if (stage.is_inf)
			mul_result = {stage.mul_sign, 8'hff, 23'd0};
		else
			mul_result = {stage.mul_sign, mul_exp, mul_rounded};
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			result <= '0;
		else if (norm_en)
		begin
			case (stage.op)
				OP_FGT, OP_FLT, OP_FEQ: result <= {31'd0, compare_result};
				OP_FMUL: result <= mul_result;
				default: result <= add_result;
			endcase
		end
	end
endmodule

`default_nettype wire

/* verilog/fp_unit_top.sv */
/*
 * Floating point unit top level
 * APB slave port, controller, datapath and done interrupt
 */
`timescale 1ns/100ps
`default_nettype none

module fp_unit_top #(
	parameter int MUL_RADIX_BITS = 2
)(
	input wire clk,
	input wire reset,
	input wire fp_pkg::apb_addr_t paddr,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic irq);

	import fp_pkg::*;

	localparam int MUL_STEPS = 24 / MUL_RADIX_BITS;
	localparam int STEP_WIDTH = $clog2(MUL_STEPS + 1);

	float_t operand_a;
	float_t operand_b;
	float_t result;
	fp_op_t op;
	significand_t mul_a;
	significand_t mul_b;
	logic start, busy, done;
	logic align_en, mul_start, mul_step, norm_en, last_step;

	fp_stage_if stage();

	// Multiplier significands with the hidden bit restored
	assign mul_a = {operand_a[30:23] != '0, operand_a[22:0]};
	assign mul_b = {operand_b[30:23] != '0, operand_b[22:0]};
	assign irq = done;

	fp_apb_regs apb_regs(.clk(clk), .reset(reset), .paddr(paddr), .psel(psel),
		.penable(penable), .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .pslverr(pslverr), .operand_a(operand_a), .operand_b(operand_b),
		.op(op), .start(start), .busy(busy), .done(done), .result(result));

	fp_op_ctrl #(.MUL_RADIX_BITS(MUL_RADIX_BITS)) op_ctrl(.clk(clk), .reset(reset),
		.start(start), .op(op), .last_step(last_step), .align_en(align_en),
		.mul_start(mul_start), .mul_step(mul_step), .norm_en(norm_en), .busy(busy),
		.done(done));

	fp_step_counter #(.WIDTH(STEP_WIDTH)) step_counter(.clk(clk), .reset(reset),
		.load(mul_start), .step(mul_step), .steps(STEP_WIDTH'(MUL_STEPS)),
		.last_step(last_step));

	fp_unpack_align unpack_align(.clk(clk), .reset(reset), .align_en(align_en),
		.operand_a(operand_a), .operand_b(operand_b), .op(op), .stage(stage.front));

	fp_seq_multiplier #(.MUL_RADIX_BITS(MUL_RADIX_BITS)) seq_multiplier(.clk(clk),
		.reset(reset), .mul_start(mul_start), .mul_step(mul_step), .mul_a(mul_a),
		.mul_b(mul_b), .stage(stage.front));

	fp_normalize_round normalize_round(.clk(clk), .reset(reset), .norm_en(norm_en),
		.stage(stage.back), .result(result));
endmodule

`default_nettype wire

/* sim/fp_unit_tb.sv */
/*
 * Testbench for the APB floating point unit
 * Runs operations from the pattern file, checks results, status, latency and bus errors
 */
`timescale 1ns/100ps
`default_nettype none

module fp_unit_tb;
	import fp_pkg::*;

	localparam int MUL_RADIX_BITS = 2;
	localparam int MUL_STEPS = 24 / MUL_RADIX_BITS;
	localparam int MAX_TESTS = 64;
	localparam int DONE_TIMEOUT = 100;
	localparam int POLL_TIMEOUT = 50;

	logic clk;
	logic reset;
	apb_addr_t paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic irq;
	int unsigned seed;

	// Four words per test: opcode, operand A, operand B, expected result
	logic [31:0] patterns [0:4*MAX_TESTS-1];

	fp_unit_top #(.MUL_RADIX_BITS(MUL_RADIX_BITS)) dut0(.clk(clk), .reset(reset),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr), .irq(irq));

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	// Prints the reason and ends the run
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("test failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
			abort_run($sformatf("[FAIL] %s expected %08h actual %08h", name, expected, actual));
	endtask

	// Setup phase, then access phase; pready is tied high so one access cycle suffices
	task automatic write_reg(input apb_addr_t addr, input logic [31:0] data, output logic err);
		@(posedge clk);
		paddr <= addr;
		pwrite <= 1'b1;
		pwdata <= data;
		psel <= 1'b1;
		penable <= 1'b0;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		if (pready !== 1'b1)
			abort_run("pready was low in a write access phase");
		err = pslverr;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic read_reg(input apb_addr_t addr, output logic [31:0] data, output logic err);
		@(posedge clk);
		paddr <= addr;
		pwrite <= 1'b0;
		psel <= 1'b1;
		penable <= 1'b0;
		@(posedge clk);
		penable <= 1'b1;
		// Read data is combinational from paddr, stable mid-cycle
		@(negedge clk);
		if (pready !== 1'b1)
			abort_run("pready was low in a read access phase");
		data = prdata;
		err = pslverr;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	// Counts cycles from the end of the control write until irq rises again
	// irq of the previous operation has to drop first
	task automatic wait_done(input string name, output int cycles);
		logic seen_low;
		seen_low = 1'b0;
		cycles = 0;
		while (!(seen_low && irq === 1'b1))
		begin
			@(negedge clk);
			cycles++;
			if (irq === 1'b0)
				seen_low = 1'b1;
			// Controller is in align here
			if (cycles == 2)
				check_value({name, " irq cleared by start"}, 32'd0, {31'd0, irq});
			if (cycles > DONE_TIMEOUT)
				abort_run($sformatf("%s: done did not rise within %0d cycles", name,
					DONE_TIMEOUT));
		end
	endtask

	// Reads status until done is set, a bounded number of times
	task automatic poll_done(input string name);
		logic [31:0] status;
		logic err;
		int polls;
		polls = 0;
		status = '0;
		while (status[1] !== 1'b1)
		begin
			read_reg(REG_STATUS, status, err);
			polls++;
			if (polls > POLL_TIMEOUT)
				abort_run($sformatf("%s: status never showed done after %0d reads", name,
					POLL_TIMEOUT));
		end
	endtask

	task automatic run_pattern(input int index);
		logic [31:0] op_word;
		logic [31:0] data;
		logic err;
		string name;
		int cycles;
		int latency;
		op_word = patterns[4*index];
		name = $sformatf("pattern %0d op %0d", index, op_word);
		write_reg(REG_OPERAND_A, patterns[4*index+1], err);
		check_value({name, " operand A pslverr"}, 32'd0, {31'd0, err});
		write_reg(REG_OPERAND_B, patterns[4*index+2], err);
		check_value({name, " operand B pslverr"}, 32'd0, {31'd0, err});
		write_reg(REG_CONTROL, op_word, err);
		check_value({name, " control pslverr"}, 32'd0, {31'd0, err});
		wait_done(name, cycles);
		// Start pulse, align, normalize and one cycle per multiply step
		latency = op_word[2:0] == OP_FMUL ? 4 + MUL_STEPS : 4;
		check_value({name, " done latency"}, latency, cycles);
		read_reg(REG_STATUS, data, err);
		check_value({name, " status"}, 32'h2, data);
		read_reg(REG_RESULT, data, err);
		check_value({name, " result"}, patterns[4*index+3], data);
	endtask

	// Bus errors during a running multiply must leave it untouched
	task automatic check_bus_errors();
		logic [31:0] data;
		logic err;
		write_reg(REG_OPERAND_A, 32'h3fc00000, err);
		write_reg(REG_OPERAND_B, 32'h3fc00000, err);
		write_reg(REG_CONTROL, {29'd0, OP_FMUL}, err);
		check_value("error test start pslverr", 32'd0, {31'd0, err});
		write_reg(REG_CONTROL, {29'd0, OP_FADD}, err);
		check_value("control write while busy pslverr", 32'd1, {31'd0, err});
		read_reg(5'h14, data, err);
		check_value("unmapped read pslverr", 32'd1, {31'd0, err});
		write_reg(5'h1c, 32'h12345678, err);
		check_value("unmapped write pslverr", 32'd1, {31'd0, err});
		write_reg(REG_STATUS, 32'h3, err);
		check_value("status write pslverr", 32'd1, {31'd0, err});
		poll_done("error test");
		read_reg(REG_CONTROL, data, err);
		check_value("error test opcode kept", {29'd0, OP_FMUL}, data);
		// 1.5 times 1.5
		read_reg(REG_RESULT, data, err);
		check_value("error test result", 32'h40100000, data);
		@(negedge clk);
		check_value("error test irq", 32'd1, {31'd0, irq});
	endtask

	initial
	begin
		int index;
		logic [31:0] data;
		logic err;
		reset = 1'b1;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		seed = 32'h20941c24;
		void'($urandom(seed));
		$readmemh("sim/fp_unit_patterns.hex", patterns);
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		read_reg(REG_STATUS, data, err);
		check_value("reset status", 32'd0, data);
		check_value("reset status pslverr", 32'd0, {31'd0, err});
		read_reg(REG_RESULT, data, err);
		check_value("reset result", 32'd0, data);
		@(negedge clk);
		check_value("reset irq", 32'd0, {31'd0, irq});

		// Patterns until the all-ones opcode line
		index = 0;
		while (patterns[4*index] !== 32'hffffffff)
		begin
			if ($isunknown(patterns[4*index]))
				abort_run("pattern file is missing or has no end line");
			run_pattern(index);
			repeat ($urandom % 4) @(posedge clk);
			index++;
		end

		check_bus_errors();
		$display("test passed");
		$finish;
	end
endmodule

`default_nettype wire

/* vlog.f */
verilog/fp_pkg.sv
verilog/fp_stage_if.sv
verilog/fp_apb_regs.sv
verilog/fp_op_ctrl.sv
verilog/fp_step_counter.sv
verilog/fp_unpack_align.sv
verilog/fp_seq_multiplier.sv
verilog/fp_normalize_round.sv
verilog/fp_unit_top.sv
sim/fp_unit_tb.sv

/* sim/fp_unit_patterns.hex */
// Columns: opcode, operand A, operand B, expected result (IEEE single words)
// Opcodes 0 add, 1 sub, 2 mul, 3 gt, 4 lt, 5 eq; the all-ones line ends the list
0 3f800000 40000000 40400000
0 3fc00000 3fc00000 40400000
1 40a00000 40400000 40000000
1 40400000 40a00000 c0000000
0 3f800000 bf800000 00000000
1 7f800000 7f800000 7fffffff
0 7f800000 3f800000 7f800000
0 3f800001 33800000 3f800002
2 3fc00000 40000000 40400000
2 3fc00000 3fc00000 40100000
2 c0000000 40400000 c0c00000
2 3f800001 3fc00000 3fc00002
2 3f800003 3fc00000 3fc00004
2 3ffffffe 3f800001 40000000
2 00000000 7f800000 7fffffff
3 40000000 3f800000 00000001
4 40000000 3f800000 00000000
4 3f800000 40000000 00000001
5 40400000 40400000 00000001
5 7fc00000 7fc00000 00000000
3 bf800000 c0000000 00000001
5 00000000 80000000 00000001
ffffffff 00000000 00000000 00000000
